//--- Makefile
# Verilator build and run of the receive unit testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -f list.f --top-module tb_usb_rx_unit -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/frame_parser.sv
// Frame parser FSM with header and trailer checks, count, direction and sub-address registers
`timescale 1ns/1ps

module frame_parser
    import usb_fifo_pkg::*;
    import frame_pkg::*;
(
    input  logic       clk,
    input  logic       n_reset,
    input  fifo_byte_t byte_i,
    input  logic       tx_busy_i,
    input  logic       wr_done_i,
    input  logic       endtx_i,
    output logic       fetch_o,
    output wr_req_t    wr_req_o,
    output read_req_t  read_req_o,
    output logic       runtx_o,
    output logic       busy_o,
    output logic       header_error_o,
    output logic       trailer_error_o
);

    rx_state_t   state_q;
    rx_state_t   state_d;

    // Frame fields
    usb_byte_t   count_q;
    usb_byte_t   len_msb_q;
    subadd_t     subadd_q;
    logic        read_q;

    // Write request and progress
    byte_count_t wr_cnt_q;
    logic        wr_valid_q;
    logic        wr_first_q;
    usb_byte_t   wr_data_q;

    logic        header_ok;
    logic        trailer_ok;
    logic        last_write;

    assign header_ok  = (byte_i.data == FRAME_HEADER);
    assign trailer_ok = (byte_i.data == FRAME_TRAILER);
    // count+1 writes in total, this is the last one
    assign last_write = (wr_cnt_q == {1'b0, count_q});

    // -------------------------------------------------------------------
    // Next state
    // -------------------------------------------------------------------

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            // Transmit side must be quiet before a new frame
            ST_IDLE:
                if (!tx_busy_i)
                    state_d = ST_HEADER;
            ST_HEADER:
                if (byte_i.valid)
                    state_d = header_ok ? ST_COUNT : ST_IDLE;
            ST_COUNT:
                if (byte_i.valid)
                    state_d = ST_CONTROL;
            ST_CONTROL:
                if (byte_i.valid)
                    state_d = byte_i.data[CTRL_READ_BIT] ? ST_COUNT_MSB : ST_DATA;
            ST_DATA:
                if (byte_i.valid)
                    state_d = ST_WRITE;
            // Wait for the writer to finish the strobe
            ST_WRITE:
                if (wr_done_i)
                    state_d = last_write ? ST_TRAILER : ST_DATA;
            ST_COUNT_MSB:
                if (byte_i.valid)
                    state_d = ST_TRAILER;
            ST_TRAILER:
                if (byte_i.valid)
                    state_d = (trailer_ok && read_q) ? ST_RUNTX : ST_IDLE;
            ST_RUNTX:
                if (endtx_i)
                    state_d = ST_IDLE;
            default:
                state_d = ST_IDLE;
        endcase
    end

    // -------------------------------------------------------------------
    // Control registers
    // -------------------------------------------------------------------

    always_ff @(posedge clk or negedge n_reset)
    begin
        if (!n_reset)
        begin
            state_q         <= ST_IDLE;
            read_q          <= 1'b0;
            wr_cnt_q        <= '0;
            wr_valid_q      <= 1'b0;
            wr_first_q      <= 1'b0;
            header_error_o  <= 1'b0;
            trailer_error_o <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            // Single-cycle error pulses
            header_error_o  <= (state_q == ST_HEADER) && byte_i.valid && !header_ok;
            trailer_error_o <= (state_q == ST_TRAILER) && byte_i.valid && !trailer_ok;
            case (state_q)
                ST_CONTROL:
                    if (byte_i.valid)
                    begin
                        read_q   <= byte_i.data[CTRL_READ_BIT];
                        wr_cnt_q <= '0;
                    end
                ST_DATA:
                    if (byte_i.valid)
                    begin
                        wr_valid_q <= 1'b1;
                        wr_first_q <= (wr_cnt_q == '0);
                    end
                ST_WRITE:
                    if (wr_done_i)
                    begin
                        wr_valid_q <= 1'b0;
                        wr_first_q <= 1'b0;
                        wr_cnt_q   <= wr_cnt_q + byte_count_t'(1);
                    end
                default:
                    ;
            endcase
        end
    end

    // Frame fields, loaded as each byte arrives
    always_ff @(posedge clk)
    begin
        if (byte_i.valid)
        begin
            case (state_q)
                ST_COUNT:     count_q   <= byte_i.data;
                ST_CONTROL:   subadd_q  <= byte_i.data[CTRL_READ_BIT-1:0];
                ST_COUNT_MSB: len_msb_q <= byte_i.data;
                ST_DATA:      wr_data_q <= byte_i.data;
                default:      ;
            endcase
        end
    end

    // -------------------------------------------------------------------
    // Outputs
    // -------------------------------------------------------------------

    // Byte wanted from the reader
    assign fetch_o = state_q inside {ST_HEADER, ST_COUNT, ST_CONTROL,
                                     ST_DATA, ST_COUNT_MSB, ST_TRAILER};

    assign busy_o  = (state_q == ST_DATA) || (state_q == ST_WRITE);
    assign runtx_o = (state_q == ST_RUNTX);

    assign wr_req_o = '{valid: wr_valid_q, first: wr_first_q,
                        subadd: subadd_q, data: wr_data_q};

    // Count byte is the LSB of the read length
    assign read_req_o = '{subadd: subadd_q, len: {len_msb_q, count_q}};

endmodule

//--- design/frame_pkg.sv
// Frame markers, control-byte fields, parser state enum and parser handoff structs
package frame_pkg;

    import usb_fifo_pkg::*;

    // -------------------------------------------------------------------
    // Frame markers and control byte layout
    // -------------------------------------------------------------------

    // First byte of every frame
    localparam usb_byte_t FRAME_HEADER  = 8'hAA;
    // Last byte of every frame
    localparam usb_byte_t FRAME_TRAILER = 8'h55;

    // Control byte, bit 7 set for a read request
    localparam int CTRL_READ_BIT = 7;

    // -------------------------------------------------------------------
    // Field widths
    // -------------------------------------------------------------------

    // Peripheral sub-address, low bits of the control byte
    typedef logic [CTRL_READ_BIT-1:0] subadd_t;

    // Write counter, one bit wider than the count byte
    typedef logic [8:0] byte_count_t;

    // Read length, MSB byte then count byte as LSB
    typedef logic [15:0] read_len_t;

    // -------------------------------------------------------------------
    // Parser FSM
    // -------------------------------------------------------------------

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_HEADER,
        ST_COUNT,
        ST_CONTROL,
        ST_DATA,
        ST_WRITE,
        ST_COUNT_MSB,
        ST_TRAILER,
        ST_RUNTX
    } rx_state_t;

    // -------------------------------------------------------------------
    // Handoff structs
    // -------------------------------------------------------------------

    // Parser to writer, valid held until wr_done
    typedef struct packed {
        logic      valid;
        logic      first;
        subadd_t   subadd;
        usb_byte_t data;
    } wr_req_t;

    // Parser to transmit side, steady while runtx is high
    typedef struct packed {
        subadd_t   subadd;
        read_len_t len;
    } read_req_t;

endpackage

//--- design/periph_writer.sv
// Peripheral bus writer with n_write strobe, n_wait handling and n_sync first-write marking
`timescale 1ns/1ps

module periph_writer
    import usb_fifo_pkg::*;
    import frame_pkg::*;
(
    input  logic      clk,
    input  logic      n_reset,
    input  wr_req_t   wr_req_i,
    input  logic      n_wait_i,
    output usb_byte_t data_o,
    output subadd_t   subadd_o,
    output logic      n_write_o,
    output logic      n_sync_o,
    output logic      wr_done_o
);

    logic start;
    logic finish;

    // -------------------------------------------------------------------
    // Strobe start and end
    // -------------------------------------------------------------------

    // New request, but not the one just completed
    // valid is still high during the wr_done cycle
    assign start = wr_req_i.valid && n_write_o && !wr_done_o;

    // Peripheral ready while the strobe is active
    assign finish = !n_write_o && n_wait_i;

    // -------------------------------------------------------------------
    // Bus and strobe registers
    // -------------------------------------------------------------------

    always_ff @(posedge clk or negedge n_reset)
    begin
        if (!n_reset)
        begin
            n_write_o <= 1'b1;
            n_sync_o  <= 1'b1;
            wr_done_o <= 1'b0;
            data_o    <= '0;
            subadd_o  <= '0;
        end
        else
        begin
            // One-cycle done pulse, same cycle as the release
            wr_done_o <= finish;
            if (start)
            begin
                n_write_o <= 1'b0;
                // Sync follows the strobe only on the first byte
                n_sync_o  <= !wr_req_i.first;
                data_o    <= wr_req_i.data;
                subadd_o  <= wr_req_i.subadd;
            end
            else if (finish)
            begin
                n_write_o <= 1'b1;
                n_sync_o  <= 1'b1;
                // Idle bus reads as zero
                data_o    <= '0;
                subadd_o  <= '0;
            end
        end
    end

endmodule

//--- design/usb_fifo_pkg.sv
// Host FIFO byte types, reader handoff struct and rd strobe timing constants
package usb_fifo_pkg;

    // -------------------------------------------------------------------
    // Byte types on the FT245 side
    // -------------------------------------------------------------------

    // One byte as read from the host FIFO
    typedef logic [7:0] usb_byte_t;

    // Byte handed from reader to parser
    // valid is a single-cycle pulse
    typedef struct packed {
        logic      valid;
        usb_byte_t data;
    } fifo_byte_t;

    // -------------------------------------------------------------------
    // rd strobe timing
    // -------------------------------------------------------------------

    // Cycles rd stays low, covers the FIFO minimum strobe width
    localparam int RD_LOW_CYCLES = 2;

    // Strobe counter sized to reach RD_LOW_CYCLES
    localparam int RD_CNT_W = $clog2(RD_LOW_CYCLES + 1);

    typedef logic [RD_CNT_W-1:0] rd_cnt_t;

endpackage

//--- design/usb_fifo_reader.sv
// FT245 FIFO reader with rxf falling-edge latch, rd strobe timer and byte capture
`timescale 1ns/1ps

module usb_fifo_reader
    import usb_fifo_pkg::*;
(
    input  logic       clk,
    input  logic       n_reset,
    input  logic       rxf_i,
    input  usb_byte_t  usb_data_i,
    input  logic       fetch_i,
    output logic       rd_o,
    output fifo_byte_t byte_o
);

    // rxf synchronizer and edge history
    logic      rxf_meta_q;
    logic      rxf_sync_q;
    logic      rxf_prev_q;
    logic      rxf_fall;
    logic      rxf_latch_q;

    // Strobe control
    rd_cnt_t   rd_cnt_q;
    logic      rd_start;
    logic      rd_last;

    // Capture pipeline
    logic      cap_q;
    logic      valid_q;
    usb_byte_t data_q;

    // -------------------------------------------------------------------
    // rxf synchronizer and falling-edge latch
    // -------------------------------------------------------------------

    assign rxf_fall = rxf_prev_q && !rxf_sync_q;

    always_ff @(posedge clk or negedge n_reset)
    begin
        if (!n_reset)
        begin
            // FIFO empty until told otherwise
            rxf_meta_q  <= 1'b1;
            rxf_sync_q  <= 1'b1;
            rxf_prev_q  <= 1'b1;
            rxf_latch_q <= 1'b0;
        end
        else
        begin
            rxf_meta_q <= rxf_i;
            rxf_sync_q <= rxf_meta_q;
            rxf_prev_q <= rxf_sync_q;
            // A fresh edge wins over the clear
            if (rxf_fall)
                rxf_latch_q <= 1'b1;
            else if (rd_start || rxf_sync_q)
                rxf_latch_q <= 1'b0;
        end
    end

    // -------------------------------------------------------------------
    // rd strobe
    // -------------------------------------------------------------------

    // Only one byte in flight, wait for the previous valid to pass
    assign rd_start = rd_o && !cap_q && !valid_q && fetch_i && rxf_latch_q;

    // Last low cycle of the strobe
    assign rd_last = !rd_o && (rd_cnt_q == rd_cnt_t'(RD_LOW_CYCLES));

    always_ff @(posedge clk or negedge n_reset)
    begin
        if (!n_reset)
        begin
            rd_o     <= 1'b1;
            rd_cnt_q <= '0;
            cap_q    <= 1'b0;
            valid_q  <= 1'b0;
        end
        else
        begin
            if (rd_start)
            begin
                rd_o     <= 1'b0;
                rd_cnt_q <= rd_cnt_t'(1);
            end
            else if (rd_last)
            begin
                rd_o     <= 1'b1;
                rd_cnt_q <= '0;
            end
            else if (!rd_o)
                rd_cnt_q <= rd_cnt_q + rd_cnt_t'(1);
            // valid one cycle after rd rises
            cap_q   <= rd_last;
            valid_q <= cap_q;
        end
    end

    // Data sampled while rd is still low
    always_ff @(posedge clk)
    begin
        if (rd_last)
            data_q <= usb_data_i;
    end

    assign byte_o = '{valid: valid_q, data: data_q};

endmodule

//--- design/usb_rx_unit.sv
// Receive unit top level with FIFO reader, frame parser and peripheral writer
`timescale 1ns/1ps

module usb_rx_unit
    import usb_fifo_pkg::*;
    import frame_pkg::*;
(
    input  logic      clk,
    input  logic      n_reset,
    // Host FIFO
    input  logic      rxf_i,
    input  usb_byte_t usb_data_i,
    output logic      rd_o,
    // Peripheral bus
    input  logic      n_wait_i,
    output usb_byte_t data_o,
    output subadd_t   subadd_o,
    output logic      n_write_o,
    output logic      n_sync_o,
    // Transmit side
    input  logic      tx_busy_i,
    input  logic      endtx_i,
    output logic      runtx_o,
    output read_req_t read_req_o,
    // Status
    output logic      busy_o,
    output logic      header_error_o,
    output logic      trailer_error_o
);

    logic       fetch;
    fifo_byte_t fifo_byte;
    wr_req_t    wr_req;
    logic       wr_done;

    // Host FIFO side
    usb_fifo_reader reader_inst (
        .clk        (clk),
        .n_reset    (n_reset),
        .rxf_i      (rxf_i),
        .usb_data_i (usb_data_i),
        .fetch_i    (fetch),
        .rd_o       (rd_o),
        .byte_o     (fifo_byte)
    );

    // Frame decode
    frame_parser parser_inst (
        .clk             (clk),
        .n_reset         (n_reset),
        .byte_i          (fifo_byte),
        .tx_busy_i       (tx_busy_i),
        .wr_done_i       (wr_done),
        .endtx_i         (endtx_i),
        .fetch_o         (fetch),
        .wr_req_o        (wr_req),
        .read_req_o      (read_req_o),
        .runtx_o         (runtx_o),
        .busy_o          (busy_o),
        .header_error_o  (header_error_o),
        .trailer_error_o (trailer_error_o)
    );

    // Peripheral bus side
    periph_writer writer_inst (
        .clk       (clk),
        .n_reset   (n_reset),
        .wr_req_i  (wr_req),
        .n_wait_i  (n_wait_i),
        .data_o    (data_o),
        .subadd_o  (subadd_o),
        .n_write_o (n_write_o),
        .n_sync_o  (n_sync_o),
        .wr_done_o (wr_done)
    );

endmodule

//--- list.f
design/usb_fifo_pkg.sv
design/frame_pkg.sv
design/usb_fifo_reader.sv
design/frame_parser.sv
design/periph_writer.sv
design/usb_rx_unit.sv
verification/rx_checker.sv
verification/tb_usb_rx_unit.sv

//--- verification/rx_checker.sv
// Checker with frame log input, reference function and comparison of writes, errors and handoffs
`timescale 1ns/1ps

module rx_checker
    import usb_fifo_pkg::*;
    import frame_pkg::*;
(
    input  logic      clk,
    input  logic      n_reset,
    // Frame log from the stimulus
    input  logic      log_valid_i,
    input  usb_byte_t log_byte_i,
    input  logic      log_end_i,
    // Observed DUT pins
    input  logic      rd_o,
    input  logic      tx_busy_i,
    input  logic      n_write_o,
    input  logic      n_sync_o,
    input  usb_byte_t data_o,
    input  subadd_t   subadd_o,
    input  logic      runtx_o,
    input  read_req_t read_req_o,
    input  logic      endtx_i,
    input  logic      busy_o,
    input  logic      header_error_o,
    input  logic      trailer_error_o,
    // Status back to the testbench
    output int        err_count_o,
    output int        missing_o
);

    // One expected bus write
    typedef struct packed {
        logic      first;
        subadd_t   subadd;
        usb_byte_t data;
    } bus_write_t;

    bus_write_t exp_wr_q[$];
    read_req_t  exp_rd_q[$];
    int         herr_left;
    int         terr_left;

    // Frame being logged
    usb_byte_t  frame_buf[0:299];
    int         frame_len;

    // Previous samples and strobe capture
    logic       wr_prev;
    logic       rtx_prev;
    logic       rd_prev;
    logic       endtx_prev;
    bus_write_t cur_wr;
    bus_write_t exp_wr;

    // -------------------------------------------------------------------
    // Reference model of one frame
    // -------------------------------------------------------------------

    function automatic void expect_frame();
        usb_byte_t count;
        usb_byte_t ctrl;
        usb_byte_t trailer;
        int        i;
        if (frame_len == 0)
            return;
        // Lone wrong header, one error and nothing else
        if (frame_buf[0] != 8'hAA)
        begin
            herr_left++;
            return;
        end
        count = frame_buf[1];
        ctrl  = frame_buf[2];
        if (ctrl[7])
        begin
            // Read, MSB byte then trailer
            trailer = frame_buf[4];
            if (trailer == 8'h55)
                exp_rd_q.push_back('{subadd: ctrl[6:0], len: {frame_buf[3], count}});
            else
                terr_left++;
        end
        else
        begin
            // Writes happen before the trailer is seen
            for (i = 0; i <= int'(count); i++)
                exp_wr_q.push_back('{first: (i == 0), subadd: ctrl[6:0],
                                     data: frame_buf[3 + i]});
            trailer = frame_buf[4 + int'(count)];
            if (trailer != 8'h55)
                terr_left++;
        end
    endfunction

    // -------------------------------------------------------------------
    // Comparison, on pre-edge values
    // -------------------------------------------------------------------

    initial
    begin
        err_count_o = 0;
        missing_o   = 0;
        herr_left   = 0;
        terr_left   = 0;
        frame_len   = 0;
    end

    always @(posedge clk)
    begin
        // Frame log
        if (log_valid_i)
        begin
            frame_buf[frame_len] = log_byte_i;
            frame_len++;
        end
        if (log_end_i)
        begin
            expect_frame();
            frame_len = 0;
        end

        if (!n_reset)
        begin
            wr_prev    = 1'b1;
            rtx_prev   = 1'b0;
            rd_prev    = 1'b1;
            endtx_prev = 1'b0;
        end
        else
        begin
            // rd strobe while gated
            if (!rd_o && rd_prev && tx_busy_i)
            begin
                $display("Error at %0t: rd strobe started while tx_busy high", $time);
                err_count_o++;
            end

            // Strobe start, capture bus
            if (!n_write_o && wr_prev)
                cur_wr = '{first: !n_sync_o, subadd: subadd_o, data: data_o};
            else if (!n_write_o)
            begin
                if (data_o != cur_wr.data || subadd_o != cur_wr.subadd
                    || n_sync_o != !cur_wr.first)
                begin
                    $display("Error at %0t: bus changed during write strobe", $time);
                    err_count_o++;
                end
            end

            // Strobe end, compare with reference
            if (n_write_o && !wr_prev)
            begin
                if (exp_wr_q.size() == 0)
                begin
                    $display("Error at %0t: unexpected bus write %h", $time, cur_wr.data);
                    err_count_o++;
                end
                else
                begin
                    exp_wr = exp_wr_q.pop_front();
                    if (cur_wr.data != exp_wr.data || cur_wr.subadd != exp_wr.subadd
                        || cur_wr.first != exp_wr.first)
                    begin
                        $display("Error at %0t: write got %h@%h first %b, expected %h@%h first %b",
                                 $time, cur_wr.data, cur_wr.subadd, cur_wr.first,
                                 exp_wr.data, exp_wr.subadd, exp_wr.first);
                        err_count_o++;
                    end
                end
            end

            if (n_write_o && !n_sync_o)
            begin
                $display("Error at %0t: n_sync low outside a write strobe", $time);
                err_count_o++;
            end

            // Read handoff
            if (runtx_o && !rtx_prev)
            begin
                if (exp_rd_q.size() == 0)
                begin
                    $display("Error at %0t: unexpected runtx", $time);
                    err_count_o++;
                end
                else if (read_req_o != exp_rd_q.pop_front())
                begin
                    $display("Error at %0t: read request %h mismatch", $time, read_req_o);
                    err_count_o++;
                end
            end
            if (!runtx_o && rtx_prev && !endtx_prev)
            begin
                $display("Error at %0t: runtx dropped without endtx", $time);
                err_count_o++;
            end

            // Error pulses
            if (header_error_o)
            begin
                if (herr_left == 0)
                begin
                    $display("Error at %0t: unexpected header error", $time);
                    err_count_o++;
                end
                else
                    herr_left--;
            end
            if (trailer_error_o)
            begin
                if (terr_left == 0)
                begin
                    $display("Error at %0t: unexpected trailer error", $time);
                    err_count_o++;
                end
                else
                    terr_left--;
            end

            // busy covers the data phase of a write frame only
            if (!n_write_o && !busy_o)
            begin
                $display("Error at %0t: busy low during a write strobe", $time);
                err_count_o++;
            end
            if (busy_o && (runtx_o || header_error_o || trailer_error_o))
            begin
                $display("Error at %0t: busy high outside a write frame", $time);
                err_count_o++;
            end

            wr_prev    = n_write_o;
            rtx_prev   = runtx_o;
            rd_prev    = rd_o;
            endtx_prev = endtx_i;
        end
        missing_o = exp_wr_q.size() + exp_rd_q.size() + herr_left + terr_left;
    end

endmodule

//--- verification/tb_usb_rx_unit.sv
// Testbench top with clock, reset, host FIFO model, peripheral and transmit models, stimulus, watchdog
`timescale 1ns/1ps

module tb_usb_rx_unit
    import usb_fifo_pkg::*;
    import frame_pkg::*;
();

    logic        clk;
    logic        n_reset;
    logic        rxf_i;
    usb_byte_t   usb_data_i;
    logic        rd_o;
    logic        n_wait_i;
    usb_byte_t   data_o;
    subadd_t     subadd_o;
    logic        n_write_o;
    logic        n_sync_o;
    logic        tx_busy_i;
    logic        endtx_i;
    logic        runtx_o;
    read_req_t   read_req_o;
    logic        busy_o;
    logic        header_error_o;
    logic        trailer_error_o;

    // Frame log towards the checker
    logic        log_valid;
    usb_byte_t   log_byte;
    logic        log_end;
    int          err_count;
    int          missing;

    usb_byte_t   host_q[$];
    usb_byte_t   frame_q[$];
    logic [31:0] rng_state;
    int          total_bytes;
    logic        all_queued;

    usb_rx_unit usb_rx_unit_inst (.*);

    rx_checker checker_inst (
        .clk (clk), .n_reset (n_reset),
        .log_valid_i (log_valid), .log_byte_i (log_byte), .log_end_i (log_end),
        .rd_o (rd_o), .tx_busy_i (tx_busy_i),
        .n_write_o (n_write_o), .n_sync_o (n_sync_o),
        .data_o (data_o), .subadd_o (subadd_o),
        .runtx_o (runtx_o), .read_req_o (read_req_o), .endtx_i (endtx_i),
        .busy_o (busy_o),
        .header_error_o (header_error_o), .trailer_error_o (trailer_error_o),
        .err_count_o (err_count), .missing_o (missing)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    // -------------------------------------------------------------------
    // Frame builders
    // -------------------------------------------------------------------

    // Hand the built frame to the host FIFO and the checker log
    task automatic queue_frame();
        int i;
        for (i = 0; i < frame_q.size(); i++)
        begin
            host_q.push_back(frame_q[i]);
            @(posedge clk);
            #1;
            log_valid = 1'b1;
            log_byte  = frame_q[i];
        end
        @(posedge clk);
        #1;
        log_valid = 1'b0;
        log_end   = 1'b1;
        @(posedge clk);
        #1;
        log_end = 1'b0;
        total_bytes += frame_q.size();
        frame_q.delete();
    endtask

    // count+1 random payload bytes
    task automatic write_frame(input subadd_t sub, input usb_byte_t count,
                               input usb_byte_t trailer);
        int i;
        frame_q.push_back(8'hAA);
        frame_q.push_back(count);
        frame_q.push_back({1'b0, sub});
        for (i = 0; i <= int'(count); i++)
        begin
            rng_state = xorshift32(rng_state);
            frame_q.push_back(rng_state[7:0]);
        end
        frame_q.push_back(trailer);
        queue_frame();
    endtask

    task automatic read_frame(input subadd_t sub, input read_len_t len,
                              input usb_byte_t trailer);
        frame_q.push_back(8'hAA);
        frame_q.push_back(len[7:0]);
        frame_q.push_back({1'b1, sub});
        frame_q.push_back(len[15:8]);
        frame_q.push_back(trailer);
        queue_frame();
    endtask

    // -------------------------------------------------------------------
    // Bus models
    // -------------------------------------------------------------------

    // FT245 host, one falling rxf edge per byte
    initial
    begin : host_fifo
        usb_byte_t b;
        forever
        begin
            @(posedge clk);
            if (host_q.size() > 0)
            begin
                b = host_q.pop_front();
                #1;
                usb_data_i = b;
                rxf_i      = 1'b0;
                while (rd_o !== 1'b0)
                    @(posedge clk);
                while (rd_o !== 1'b1)
                    @(posedge clk);
                #1;
                rxf_i = 1'b1;
                // High long enough for the synchronizer to see it
                repeat (4) @(posedge clk);
            end
        end
    end

    // Peripheral stalls 0 to 3 cycles per write
    initial
    begin : periph_wait
        int k;
        forever
        begin
            @(negedge n_write_o);
            rng_state = xorshift32(rng_state);
            k = int'(rng_state[1:0]);
            if (k > 0)
            begin
                #1;
                n_wait_i = 1'b0;
                repeat (k) @(posedge clk);
                #1;
                n_wait_i = 1'b1;
            end
        end
    end

    // Transmit side answers runtx after a short delay
    initial
    begin : tx_model
        forever
        begin
            @(posedge clk);
            if (runtx_o === 1'b1)
            begin
                rng_state = xorshift32(rng_state);
                repeat (int'(rng_state[2:0])) @(posedge clk);
                #1;
                endtx_i = 1'b1;
                @(posedge clk);
                #1;
                endtx_i = 1'b0;
            end
        end
    end

    // -------------------------------------------------------------------
    // Stimulus and end of run
    // -------------------------------------------------------------------

    initial
    begin : stimulus
        n_reset     = 1'b0;
        rxf_i       = 1'b1;
        usb_data_i  = '0;
        n_wait_i    = 1'b1;
        tx_busy_i   = 1'b1;
        endtx_i     = 1'b0;
        log_valid   = 1'b0;
        log_byte    = '0;
        log_end     = 1'b0;
        rng_state   = 32'd28530;
        total_bytes = 0;
        all_queued  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        n_reset = 1'b1;

        // All frames queued while the gate holds the reader off
        write_frame(7'h12, 8'd3, 8'h55);
        read_frame(7'h05, 16'h0120, 8'h55);
        frame_q.push_back(8'h3C);
        queue_frame();
        write_frame(7'h7F, 8'd0, 8'h55);
        write_frame(7'h21, 8'd1, 8'h54);
        read_frame(7'h33, 16'h0203, 8'h00);
        write_frame(7'h4A, 8'd15, 8'h55);
        read_frame(7'h01, 16'hFFFF, 8'h55);
        all_queued = 1'b1;

        repeat (60) @(posedge clk);
        #1;
        tx_busy_i = 1'b0;

        while (host_q.size() > 0 || missing != 0)
            @(posedge clk);
        repeat (50) @(posedge clk);
        #1;
        $display("Run complete: %0d mismatches, %0d expected events missing",
                 err_count, missing);
        if (err_count == 0 && missing == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // Watchdog scaled by the number of queued bytes
    initial
    begin : watchdog
        wait (all_queued);
        repeat (total_bytes * 400 + 1000) @(posedge clk);
        $display("Timeout: the run did not finish within the cycle limit");
        $display("Checks failed");
        $finish;
    end

endmodule
